//--- hw/ddram_defines.svh
// Build-wide sizes for the DDR front end
// Included by the package and by every RTL file that sizes a port
`ifndef DDRAM_DEFINES_SVH
`define DDRAM_DEFINES_SVH

// Independent client channels, channel 0 has the highest priority
`define DDRAM_CHANNELS 4

// Client side, the address counts halfwords
`define DDRAM_CLIENT_ADDR_BITS 27
`define DDRAM_CLIENT_DATA_BITS 32

// One DDR data beat and its byte enables
`define DDRAM_BEAT_BITS 64
`define DDRAM_BE_BITS 8

// A cached read line is two beats
`define DDRAM_LINE_BITS 128

// Top nibble of the 29-bit beat address, RAM sits at 0x30000000
`define DDRAM_BASE_NIBBLE 4'b0011

`endif

//--- hw/ddram_pkg.sv
// Shared types of the DDR front end
// Referenced by scoped name from the RTL and the testbench
`include "ddram_defines.svh"

package ddram_pkg;

	// Sequencer states, a read waits for two returning beats
	typedef enum logic [1:0] {
		SEQ_IDLE       = 2'd0,
		SEQ_WRITE      = 2'd1,
		SEQ_READ_UPPER = 2'd2,
		SEQ_READ_LOWER = 2'd3
	} seq_state_e;

	typedef logic [`DDRAM_LINE_BITS-1:0] line_t;
	typedef logic [`DDRAM_BEAT_BITS-1:0] beat_t;
	typedef logic [`DDRAM_BE_BITS-1:0] beat_be_t;

	typedef logic [`DDRAM_CLIENT_ADDR_BITS-1:0] client_addr_t;
	typedef logic [`DDRAM_CLIENT_DATA_BITS-1:0] client_data_t;

endpackage

//--- hw/ddram_client_port.sv
// One client channel: captures requests on edges, keeps the 16-byte read line
// and stages a single write beat until the sequencer has sent it
`timescale 1ns/1ps
`include "ddram_defines.svh"

module ddram_client_port (
	input  logic                                  clk,
	input  logic                                  reset,
	input  ddram_pkg::client_addr_t               addr,
	input  ddram_pkg::client_data_t               din,
	input  logic                                  rd,
	input  logic [`DDRAM_CLIENT_DATA_BITS/8-1:0]  wr,
	input  logic                                  word16,
	output ddram_pkg::client_data_t               dout,
	output logic                                  busy,
	output logic                                  write_pending,
	output logic                                  write_upper,
	output logic [`DDRAM_CLIENT_ADDR_BITS-4:0]    write_line_addr,
	output ddram_pkg::beat_t                      write_beat,
	output ddram_pkg::beat_be_t                   write_be,
	output logic                                  read_pending,
	output logic [`DDRAM_CLIENT_ADDR_BITS-4:0]    read_line_addr,
	input  logic                                  write_done,
	input  logic                                  fill_upper,
	input  logic                                  fill_lower,
	input  ddram_pkg::beat_t                      fill_beat
);

	logic rd_q;
	logic wr_q;
	logic rd_edge;
	logic wr_edge;
	logic tag_hit;

	// Lane selects, the lowest address always sits in the most significant lane
	logic [1:0] half_sel;
	logic word_sel;
	logic line_half;
	logic [1:0] rd_word_sel;

	ddram_pkg::line_t line;
	ddram_pkg::client_addr_t rd_addr;
	logic rd_word16;
	ddram_pkg::beat_t lane_beat;
	ddram_pkg::beat_be_t lane_be;
	ddram_pkg::client_data_t line_word;

	assign rd_edge = rd & ~rd_q;
	assign wr_edge = (|wr) & ~wr_q;

	// The tag is the halfword address above the offset within the line
	assign tag_hit = (addr[`DDRAM_CLIENT_ADDR_BITS-1:3] == read_line_addr);

	assign half_sel = ~addr[1:0];
	assign word_sel = ~addr[1];
	assign line_half = ~addr[2];
	assign rd_word_sel = ~rd_addr[2:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else begin
			rd_q <= rd;
			wr_q <= |wr;
		end
	end

	// Move the client bytes into their lane of a 64-bit beat
	always_comb begin
		lane_beat = '0;
		lane_be = '0;
		if (word16) begin
			lane_beat[half_sel * 16 +: 16] = din[15:0];
			lane_be[half_sel * 2 +: 2] = wr[1:0];
		end else begin
			lane_beat[word_sel * 32 +: 32] = din;
			lane_be[word_sel * 4 +: 4] = wr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_pending <= 1'b0;
			read_pending <= 1'b0;
			read_line_addr <= '1;
		end else begin
			if (wr_edge) begin
				write_pending <= 1'b1;
			end else if (write_done) begin
				write_pending <= 1'b0;
			end

			// A miss keeps the new tag and waits for the line fill
			if (rd_edge) begin
				read_line_addr <= addr[`DDRAM_CLIENT_ADDR_BITS-1:3];
				if (!tag_hit) begin
					read_pending <= 1'b1;
				end
			end else if (fill_lower) begin
				read_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_edge) begin
			rd_addr <= addr;
			rd_word16 <= word16;
		end

		if (wr_edge) begin
			write_upper <= line_half;
			write_line_addr <= addr[`DDRAM_CLIENT_ADDR_BITS-1:3];
			write_beat <= lane_beat;
			write_be <= lane_be;
		end

		if (fill_upper) begin
			line[`DDRAM_LINE_BITS-1:`DDRAM_BEAT_BITS] <= fill_beat;
		end
		if (fill_lower) begin
			line[`DDRAM_BEAT_BITS-1:0] <= fill_beat;
		end

		// Keep the cached line coherent with writes that land in it
		if (wr_edge && tag_hit) begin
			for (int b = 0; b < `DDRAM_BE_BITS; b++) begin
				if (lane_be[b]) begin
					line[line_half * `DDRAM_BEAT_BITS + b * 8 +: 8] <= lane_beat[b * 8 +: 8];
				end
			end
		end
	end

	assign line_word = line[rd_word_sel * `DDRAM_CLIENT_DATA_BITS +: `DDRAM_CLIENT_DATA_BITS];

	always_comb begin
		if (!rd_word16) begin
			dout = line_word;
		end else if (rd_addr[0]) begin
			dout = {16'h0000, line_word[15:0]};
		end else begin
			dout = {16'h0000, line_word[31:16]};
		end
	end

	assign busy = read_pending | write_pending;

endmodule

//--- hw/ddram_sequencer.sv
// DDR command sequencer shared by all client channels
// Grants in fixed priority, issues one command at a time and routes read beats back
`timescale 1ns/1ps
`include "ddram_defines.svh"

module ddram_sequencer (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [`DDRAM_CHANNELS-1:0]          write_pending,
	input  logic [`DDRAM_CHANNELS-1:0]          write_upper,
	input  logic [`DDRAM_CLIENT_ADDR_BITS-4:0]  write_line_addr [`DDRAM_CHANNELS],
	input  ddram_pkg::beat_t                    write_beat [`DDRAM_CHANNELS],
	input  ddram_pkg::beat_be_t                 write_be [`DDRAM_CHANNELS],
	input  logic [`DDRAM_CHANNELS-1:0]          read_pending,
	input  logic [`DDRAM_CLIENT_ADDR_BITS-4:0]  read_line_addr [`DDRAM_CHANNELS],
	output logic [`DDRAM_CHANNELS-1:0]          write_done,
	output logic [`DDRAM_CHANNELS-1:0]          fill_upper,
	output logic [`DDRAM_CHANNELS-1:0]          fill_lower,
	output ddram_pkg::beat_t                    fill_beat,
	input  logic                                ddram_busy,
	input  ddram_pkg::beat_t                    ddram_dout,
	input  logic                                ddram_dout_ready,
	output logic [28:0]                         ddram_addr,
	output logic [7:0]                          ddram_burstcnt,
	output logic                                ddram_rd,
	output logic                                ddram_we,
	output ddram_pkg::beat_t                    ddram_din,
	output ddram_pkg::beat_be_t                 ddram_be
);

	localparam int CHAN_BITS = $clog2(`DDRAM_CHANNELS);

	ddram_pkg::seq_state_e state;
	logic [CHAN_BITS-1:0] chan;

	logic grant_write;
	logic grant_read;
	logic [CHAN_BITS-1:0] grant_chan;

	// Walk from the last channel down so the lowest pending channel wins
	always_comb begin
		grant_write = 1'b0;
		grant_read = 1'b0;
		grant_chan = '0;
		for (int i = `DDRAM_CHANNELS - 1; i >= 0; i--) begin
			if (write_pending[i]) begin
				grant_write = 1'b1;
				grant_read = 1'b0;
				grant_chan = CHAN_BITS'(i);
			end else if (read_pending[i]) begin
				grant_write = 1'b0;
				grant_read = 1'b1;
				grant_chan = CHAN_BITS'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ddram_pkg::SEQ_IDLE;
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
		end else if (!ddram_busy) begin
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
			case (state)
				ddram_pkg::SEQ_IDLE: begin
					if (grant_write) begin
						ddram_we <= 1'b1;
						state <= ddram_pkg::SEQ_WRITE;
					end else if (grant_read) begin
						ddram_rd <= 1'b1;
						state <= ddram_pkg::SEQ_READ_UPPER;
					end
				end
				ddram_pkg::SEQ_WRITE: begin
					state <= ddram_pkg::SEQ_IDLE;
				end
				ddram_pkg::SEQ_READ_UPPER: begin
					if (ddram_dout_ready) begin
						state <= ddram_pkg::SEQ_READ_LOWER;
					end
				end
				default: begin
					if (ddram_dout_ready) begin
						state <= ddram_pkg::SEQ_IDLE;
					end
				end
			endcase
		end
	end

	// Command payload, the lower line half is the odd beat
	always_ff @(posedge clk) begin
		if (!ddram_busy && state == ddram_pkg::SEQ_IDLE) begin
			chan <= grant_chan;
			if (grant_write) begin
				ddram_addr <= {`DDRAM_BASE_NIBBLE, write_line_addr[grant_chan],
					~write_upper[grant_chan]};
				ddram_burstcnt <= 8'd1;
				ddram_din <= write_beat[grant_chan];
				ddram_be <= write_be[grant_chan];
			end else if (grant_read) begin
				ddram_addr <= {`DDRAM_BASE_NIBBLE, read_line_addr[grant_chan], 1'b0};
				ddram_burstcnt <= 8'd2;
				ddram_be <= '1;
			end
		end
	end

	// Completion strobes go to the granted channel on the advancing cycle itself
	always_comb begin
		write_done = '0;
		fill_upper = '0;
		fill_lower = '0;
		if (!ddram_busy) begin
			case (state)
				ddram_pkg::SEQ_WRITE: write_done[chan] = 1'b1;
				ddram_pkg::SEQ_READ_UPPER: fill_upper[chan] = ddram_dout_ready;
				ddram_pkg::SEQ_READ_LOWER: fill_lower[chan] = ddram_dout_ready;
				default: write_done = '0;
			endcase
		end
	end

	assign fill_beat = ddram_dout;

endmodule

//--- hw/ddram.sv
// Multi-client DDR front end
// Each channel has its own client port, all share one DDR sequencer
`timescale 1ns/1ps
`include "ddram_defines.svh"

module ddram (
	input  logic                                  clk,
	input  logic                                  reset,
	input  ddram_pkg::client_addr_t               addr [`DDRAM_CHANNELS],
	input  ddram_pkg::client_data_t               din [`DDRAM_CHANNELS],
	output ddram_pkg::client_data_t               dout [`DDRAM_CHANNELS],
	input  logic [`DDRAM_CHANNELS-1:0]            rd,
	input  logic [`DDRAM_CLIENT_DATA_BITS/8-1:0]  wr [`DDRAM_CHANNELS],
	input  logic [`DDRAM_CHANNELS-1:0]            word16,
	output logic [`DDRAM_CHANNELS-1:0]            busy,
	input  logic                                  ddram_busy,
	input  ddram_pkg::beat_t                      ddram_dout,
	input  logic                                  ddram_dout_ready,
	output logic [28:0]                           ddram_addr,
	output logic [7:0]                            ddram_burstcnt,
	output logic                                  ddram_rd,
	output logic                                  ddram_we,
	output ddram_pkg::beat_t                      ddram_din,
	output ddram_pkg::beat_be_t                   ddram_be
);

	logic [`DDRAM_CHANNELS-1:0] write_pending;
	logic [`DDRAM_CHANNELS-1:0] write_upper;
	logic [`DDRAM_CLIENT_ADDR_BITS-4:0] write_line_addr [`DDRAM_CHANNELS];
	ddram_pkg::beat_t write_beat [`DDRAM_CHANNELS];
	ddram_pkg::beat_be_t write_be [`DDRAM_CHANNELS];
	logic [`DDRAM_CHANNELS-1:0] read_pending;
	logic [`DDRAM_CLIENT_ADDR_BITS-4:0] read_line_addr [`DDRAM_CHANNELS];
	logic [`DDRAM_CHANNELS-1:0] write_done;
	logic [`DDRAM_CHANNELS-1:0] fill_upper;
	logic [`DDRAM_CHANNELS-1:0] fill_lower;
	ddram_pkg::beat_t fill_beat;

	for (genvar i = 0; i < `DDRAM_CHANNELS; i++) begin : g_port
		ddram_client_port u_port (
			.clk             (clk),
			.reset           (reset),
			.addr            (addr[i]),
			.din             (din[i]),
			.rd              (rd[i]),
			.wr              (wr[i]),
			.word16          (word16[i]),
			.dout            (dout[i]),
			.busy            (busy[i]),
			.write_pending   (write_pending[i]),
			.write_upper     (write_upper[i]),
			.write_line_addr (write_line_addr[i]),
			.write_beat      (write_beat[i]),
			.write_be        (write_be[i]),
			.read_pending    (read_pending[i]),
			.read_line_addr  (read_line_addr[i]),
			.write_done      (write_done[i]),
			.fill_upper      (fill_upper[i]),
			.fill_lower      (fill_lower[i]),
			.fill_beat       (fill_beat)
		);
	end

	ddram_sequencer u_sequencer (
		.clk              (clk),
		.reset            (reset),
		.write_pending    (write_pending),
		.write_upper      (write_upper),
		.write_line_addr  (write_line_addr),
		.write_beat       (write_beat),
		.write_be         (write_be),
		.read_pending     (read_pending),
		.read_line_addr   (read_line_addr),
		.write_done       (write_done),
		.fill_upper       (fill_upper),
		.fill_lower       (fill_lower),
		.fill_beat        (fill_beat),
		.ddram_busy       (ddram_busy),
		.ddram_dout       (ddram_dout),
		.ddram_dout_ready (ddram_dout_ready),
		.ddram_addr       (ddram_addr),
		.ddram_burstcnt   (ddram_burstcnt),
		.ddram_rd         (ddram_rd),
		.ddram_we         (ddram_we),
		.ddram_din        (ddram_din),
		.ddram_be         (ddram_be)
	);

endmodule

//--- tests/ddram_mem_model.sv
// Behavioral DDR slave for the front end testbench
// Random busy, reads return the requested beats after a random latency of 1 to 6 cycles
`timescale 1ns/1ps

module ddram_mem_model (
	input  logic                clk,
	input  logic                reset,
	output logic                ddram_busy,
	output ddram_pkg::beat_t    ddram_dout,
	output logic                ddram_dout_ready,
	input  logic [28:0]         ddram_addr,
	input  logic [7:0]          ddram_burstcnt,
	input  logic                ddram_rd,
	input  logic                ddram_we,
	input  ddram_pkg::beat_t    ddram_din,
	input  ddram_pkg::beat_be_t ddram_be
);

	ddram_pkg::beat_t mem [logic [28:0]];
	integer seed = 32'hd167_10c2;
	logic [28:0] rd_next;
	int beats_left;
	int wait_cnt;

	// Untouched memory reads back a pattern folded from every address bit
	function automatic ddram_pkg::beat_t fetch(input logic [28:0] a);
		ddram_pkg::beat_t b;
		if (mem.exists(a)) begin
			return mem[a];
		end
		for (int lane = 0; lane < 8; lane++) begin
			b[lane * 8 +: 8] = a[7:0] ^ a[15:8] ^ a[23:16] ^ {3'b000, a[28:24]}
				^ 8'(lane * 37 + 8'h5c);
		end
		return b;
	endfunction

	always @(posedge clk) begin
		ddram_pkg::beat_t b;
		if (reset) begin
			beats_left = 0;
			wait_cnt = 0;
		end else if (!ddram_busy) begin
			if (ddram_we) begin
				b = fetch(ddram_addr);
				for (int lane = 0; lane < 8; lane++) begin
					if (ddram_be[lane]) begin
						b[lane * 8 +: 8] = ddram_din[lane * 8 +: 8];
					end
				end
				mem[ddram_addr] = b;
			end
			if (ddram_rd) begin
				rd_next = ddram_addr;
				beats_left = ddram_burstcnt;
				wait_cnt = 1 + $unsigned($random(seed)) % 6;
			end
		end
	end

	// A returning beat always comes with busy low so the sequencer takes it
	always @(negedge clk) begin
		if (reset) begin
			ddram_busy <= 1'b0;
			ddram_dout_ready <= 1'b0;
			ddram_dout <= '0;
		end else if (beats_left > 0 && wait_cnt == 0) begin
			ddram_busy <= 1'b0;
			ddram_dout_ready <= 1'b1;
			ddram_dout <= fetch(rd_next);
			rd_next = rd_next + 29'd1;
			beats_left = beats_left - 1;
			wait_cnt = $unsigned($random(seed)) % 3;
		end else begin
			if (wait_cnt > 0) begin
				wait_cnt = wait_cnt - 1;
			end
			ddram_dout_ready <= 1'b0;
			ddram_busy <= (($random(seed) & 3) == 0);
		end
	end

endmodule

//--- tests/ddram_assert.sv
// DDR side protocol assertions, bound into every ddram instance
`timescale 1ns/1ps

module ddram_assert (
	input logic       clk,
	input logic       reset,
	input logic       ddram_busy,
	input logic       ddram_rd,
	input logic       ddram_we,
	input logic [7:0] ddram_burstcnt
);

	a_no_rd_and_we: assert property (@(posedge clk) disable iff (reset)
		!(ddram_rd && ddram_we))
		else $error("ddram_rd and ddram_we high together");

	// A new command may only start after a cycle where the memory was free
	a_cmd_after_free: assert property (@(posedge clk) disable iff (reset)
		$rose(ddram_rd || ddram_we) |-> !$past(ddram_busy))
		else $error("command issued while ddram_busy was high");

	a_we_burst: assert property (@(posedge clk) disable iff (reset)
		ddram_we |-> ddram_burstcnt == 8'd1)
		else $error("write burst count is not 1");

	a_rd_burst: assert property (@(posedge clk) disable iff (reset)
		ddram_rd |-> ddram_burstcnt == 8'd2)
		else $error("read burst count is not 2");

endmodule

bind ddram ddram_assert u_assert (.*);

//--- tests/tb_ddram.sv
// Random multi-channel testbench for the DDR front end
// Byte model of memory plus per-channel cache tags predict data and DDR traffic
`timescale 1ns/1ps
`include "ddram_defines.svh"

module tb_ddram;

	localparam int N = `DDRAM_CHANNELS;
	localparam int OPS = 600;
	localparam int MAX_CYCLES = 40000;

	logic clk;
	logic reset;
	ddram_pkg::client_addr_t addr [N];
	ddram_pkg::client_data_t din [N];
	ddram_pkg::client_data_t dout [N];
	logic [N-1:0] rd;
	logic [3:0] wr [N];
	logic [N-1:0] word16;
	logic [N-1:0] busy;
	logic ddram_busy;
	ddram_pkg::beat_t ddram_dout;
	logic ddram_dout_ready;
	logic [28:0] ddram_addr;
	logic [7:0] ddram_burstcnt;
	logic ddram_rd;
	logic ddram_we;
	ddram_pkg::beat_t ddram_din;
	ddram_pkg::beat_be_t ddram_be;

	integer seed = 32'hd167_10c2;
	int errors = 0;
	int checks = 0;
	int ops = 0;
	int cycles = 0;
	logic [7:0] mem_bytes [logic [31:0]];
	logic [N-1:0] active;
	logic [N-1:0] is_read;
	ddram_pkg::client_data_t exp_data [N];
	int exp_miss [N];
	logic [23:0] last_tag [N];
	int miss_total [N];
	logic [28:0] exp_we_addr [N];
	ddram_pkg::beat_be_t exp_be [N];
	ddram_pkg::beat_t exp_din [N];
	int rd_round [N];
	int rd_total [N];
	int we_round [N];
	logic [28:0] rd_addr_seen [N];
	logic [28:0] we_addr_seen [N];
	ddram_pkg::beat_be_t we_be_seen [N];
	ddram_pkg::beat_t we_din_seen [N];

	ddram u_ddram (.*);
	ddram_mem_model u_mem (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Error: run stopped after %0d cycles without finishing", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// Channel windows are disjoint, so beat address bits 15:14 name the channel
	always @(posedge clk) begin
		if (!reset && !ddram_busy) begin
			if (ddram_rd) begin
				rd_round[ddram_addr[15:14]]++;
				rd_total[ddram_addr[15:14]]++;
				rd_addr_seen[ddram_addr[15:14]] = ddram_addr;
			end
			if (ddram_we) begin
				we_round[ddram_addr[15:14]]++;
				we_addr_seen[ddram_addr[15:14]] = ddram_addr;
				we_be_seen[ddram_addr[15:14]] = ddram_be;
				we_din_seen[ddram_addr[15:14]] = ddram_din;
			end
		end
	end

	// Byte k of an access counts from the most significant byte of the client word
	function automatic int lane_of(input logic [26:0] a, input logic w16, input int k);
		if (w16) begin
			return 7 - 2 * int'(a[1:0]) - k;
		end
		return 7 - 4 * int'(a[1]) - k;
	endfunction

	function automatic logic [7:0] get_byte(input logic [28:0] beat_a, input int lane);
		if (mem_bytes.exists({beat_a, 3'(lane)})) begin
			return mem_bytes[{beat_a, 3'(lane)}];
		end
		return beat_a[7:0] ^ beat_a[15:8] ^ beat_a[23:16] ^ {3'b000, beat_a[28:24]}
			^ 8'(lane * 37 + 8'h5c);
	endfunction

	task automatic compare(input string what, input int c, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error %0t: channel %0d %s got %h expected %h", $time, c, what, got, exp);
		end
	endtask

	task automatic setup_op(input int c);
		logic [26:0] a;
		logic w16;
		logic [3:0] s;
		logic [31:0] d;
		logic [28:0] beat_a;
		int lane;
		int nbytes;
		a = (27'(c) << 16) | 27'($unsigned($random(seed)) % 64);
		w16 = $random(seed);
		d = $random(seed);
		nbytes = w16 ? 2 : 4;
		beat_a = {`DDRAM_BASE_NIBBLE, a[26:2]};
		is_read[c] = $random(seed);
		addr[c] = a;
		word16[c] = w16;
		din[c] = d;
		if (is_read[c]) begin
			exp_data[c] = '0;
			for (int k = 0; k < nbytes; k++) begin
				exp_data[c] = (exp_data[c] << 8) | 32'(get_byte(beat_a, lane_of(a, w16, k)));
			end
			exp_miss[c] = (a[26:3] != last_tag[c]) ? 1 : 0;
			last_tag[c] = a[26:3];
			miss_total[c] += exp_miss[c];
			rd[c] = 1'b1;
		end else begin
			s = w16 ? 4'($unsigned($random(seed)) % 3 + 1) : 4'($unsigned($random(seed)) % 15 + 1);
			exp_we_addr[c] = beat_a;
			exp_be[c] = '0;
			exp_din[c] = '0;
			for (int k = 0; k < nbytes; k++) begin
				lane = lane_of(a, w16, k);
				if (s[nbytes - 1 - k]) begin
					exp_be[c][lane] = 1'b1;
					exp_din[c][lane * 8 +: 8] = d[(nbytes - 1 - k) * 8 +: 8];
					mem_bytes[{beat_a, 3'(lane)}] = d[(nbytes - 1 - k) * 8 +: 8];
				end
			end
			wr[c] = s;
		end
	endtask

	task automatic check_op(input int c);
		ddram_pkg::beat_t mask;
		if (active[c] && is_read[c]) begin
			compare("read data", c, 64'(dout[c]), 64'(exp_data[c]));
			compare("ddram_rd count", c, 64'(rd_round[c]), 64'(exp_miss[c]));
			if (exp_miss[c] != 0) begin
				compare("read address", c, 64'(rd_addr_seen[c]),
					64'({`DDRAM_BASE_NIBBLE, last_tag[c], 1'b0}));
			end
			compare("ddram_we count", c, 64'(we_round[c]), 64'd0);
		end else if (active[c]) begin
			compare("ddram_we count", c, 64'(we_round[c]), 64'd1);
			compare("write address", c, 64'(we_addr_seen[c]), 64'(exp_we_addr[c]));
			compare("byte enables", c, 64'(we_be_seen[c]), 64'(exp_be[c]));
			for (int b = 0; b < 8; b++) begin
				mask[b * 8 +: 8] = {8{exp_be[c][b]}};
			end
			compare("write data", c, we_din_seen[c] & mask, exp_din[c]);
			compare("ddram_rd count", c, 64'(rd_round[c]), 64'd0);
		end else begin
			compare("idle ddram traffic", c, 64'(rd_round[c] + we_round[c]), 64'd0);
		end
	endtask

	// One round starts a request on one or more channels at the same edge
	task automatic run_round();
		active = 4'($random(seed));
		if (active == '0) begin
			active[$unsigned($random(seed)) % N] = 1'b1;
		end
		for (int c = 0; c < N; c++) begin
			rd_round[c] = 0;
			we_round[c] = 0;
			if (active[c]) begin
				setup_op(c);
				ops++;
			end
		end
		@(negedge clk);
		while (busy != '0) begin
			@(negedge clk);
		end
		for (int c = 0; c < N; c++) begin
			check_op(c);
		end
		rd = '0;
		for (int c = 0; c < N; c++) begin
			wr[c] = '0;
		end
		@(negedge clk);
	endtask

	initial begin
		reset = 1'b1;
		rd = '0;
		word16 = '0;
		for (int c = 0; c < N; c++) begin
			addr[c] = '0;
			din[c] = '0;
			wr[c] = '0;
			last_tag[c] = '1;
			miss_total[c] = 0;
			rd_total[c] = 0;
		end
		repeat (4) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		compare("busy after reset", 0, 64'(busy), 64'd0);
		compare("ddram_rd after reset", 0, 64'(ddram_rd), 64'd0);
		compare("ddram_we after reset", 0, 64'(ddram_we), 64'd0);
		while (ops < OPS) begin
			run_round();
		end
		for (int c = 0; c < N; c++) begin
			compare("total ddram_rd count", c, 64'(rd_total[c]), 64'(miss_total[c]));
		end
		$display("operations %0d, checks %0d, errors %0d", ops, checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+hw
hw/ddram_pkg.sv
hw/ddram_client_port.sv
hw/ddram_sequencer.sv
hw/ddram.sv
tests/ddram_mem_model.sv
tests/ddram_assert.sv
tests/tb_ddram.sv

//--- Bender.yml
package:
  name: ddram

sources:
  - include_dirs:
      - hw
    files:
      - hw/ddram_pkg.sv
      - hw/ddram_client_port.sv
      - hw/ddram_sequencer.sv
      - hw/ddram.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/ddram_mem_model.sv
      - tests/ddram_assert.sv
      - tests/tb_ddram.sv
